// File: list.f
logic/sys_bus_pkg.sv
logic/bus_arbiter.sv
logic/kbd_bus_controller.sv
logic/mem_bus_slave.sv
logic/sys_bus_top.sv
sim/sys_bus_checker.sv
sim/sys_bus_tb.sv

// File: logic/bus_arbiter.sv
/* Round-robin bus arbiter, holds a grant until the slave acknowledges */

`timescale 1ns/1ps

module bus_arbiter
(
   input  logic                               bus_clk,
   input  logic                               arst_n,
   input  logic [sys_bus_pkg::NUM_MASTERS-1:0] br,
   input  logic                               ack,
   output logic [sys_bus_pkg::NUM_MASTERS-1:0] bg
);

   import sys_bus_pkg::*;

   // Master that received the most recent grant
   logic [$clog2(NUM_MASTERS)-1:0] last_q;
   logic [$clog2(NUM_MASTERS)-1:0] win_idx;
   logic                           win_vld;

   // Search starts just after the last winner
   always_comb
   begin
      int cand;
      win_vld = 1'b0;
      win_idx = last_q;
      for (int i = 1; i <= NUM_MASTERS; i++)
      begin
         cand = (int'(last_q) + i) % NUM_MASTERS;
         if (!win_vld && br[cand])
         begin
            win_vld = 1'b1;
            win_idx = cand[$clog2(NUM_MASTERS)-1:0];
         end
      end
   end

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         bg     <= '0;
         last_q <= '0;
      end
      else if (|bg)
      begin
         // Release after the last beat, bus stays idle one cycle
         if (ack)
            bg <= '0;
      end
      else if (win_vld)
      begin
         bg     <= {{(NUM_MASTERS-1){1'b0}}, 1'b1} << win_idx;
         last_q <= win_idx;
      end
   end

   // Only one master may drive the bus
   a_bg_onehot: assert property (@(posedge bus_clk) disable iff (!arst_n)
      $onehot0(bg));

   // Slave acknowledges only a transfer of the granted master
   a_ack_granted: assert property (@(posedge bus_clk) disable iff (!arst_n)
      ack |-> |bg);

endmodule

// File: logic/kbd_bus_controller.sv
/* Keyboard bus master: line assembler, transfer buffer, master FSM and ring pointer */

`timescale 1ns/1ps

module kbd_bus_controller
#(
   parameter logic [sys_bus_pkg::BUS_ADDR_W-1:0] BASE_ADDR = sys_bus_pkg::KBD0_BASE
)
(
   input  logic                   bus_clk,
   input  logic                   arst_n,
   input  sys_bus_pkg::key_t      key,
   input  logic                   bg,
   input  logic                   ack,
   output logic                   br,
   output sys_bus_pkg::bus_beat_t beat,
   output logic                   line_done,
   output logic                   overflow
);

   import sys_bus_pkg::*;

   typedef enum logic [3:0]
   {
      ST_IDLE = 4'b0001,
      ST_REQ  = 4'b0010,
      ST_HDR  = 4'b0100,
      ST_DATA = 4'b1000
   } state_t;

   state_t state, next_state;

   logic [$clog2(LINE_BYTES)-1:0] byte_cnt;
   logic [LINE_BYTES*8-1:0]       line_q, line_next;
   logic [LINE_BYTES*8-1:0]       xfer_buf;
   logic                          pending;
   logic                          line_full, buf_free, xfer_end;
   logic [$clog2(LINE_BEATS)-1:0] beat_cnt;
   logic [BUS_ADDR_W-1:0]         ring_ptr;

   // Line assembler, first key lands in the low byte of word 0
   always_comb
   begin
      line_next = line_q;
      line_next[byte_cnt*8 +: 8] = key.code;
   end

   assign line_full = key.valid && (&byte_cnt);
   assign xfer_end  = (state == ST_DATA) && ack;
   // Buffer can take a new line on the ack cycle
   assign buf_free  = !pending || xfer_end;

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
         byte_cnt <= '0;
      else if (key.valid)
         byte_cnt <= byte_cnt + 1'b1;
   end

   always_ff @(posedge bus_clk)
   begin
      if (key.valid)
         line_q <= line_next;
      if (line_full && buf_free)
         xfer_buf <= line_next;
   end

   // Buffer state, overflow drops the new line
   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         pending  <= 1'b0;
         overflow <= 1'b0;
      end
      else
      begin
         if (line_full && buf_free)
            pending <= 1'b1;
         else if (xfer_end)
            pending <= 1'b0;
         if (line_full && !buf_free)
            overflow <= 1'b1;
      end
   end

   // Master FSM
   always_comb
   begin
      next_state = state;
      case (state)
         ST_IDLE: if (pending || line_full) next_state = ST_REQ;
         ST_REQ:  if (bg) next_state = ST_HDR;
         ST_HDR:  next_state = ST_DATA;
         ST_DATA: if (ack) next_state = ST_IDLE;
         default: next_state = ST_IDLE;
      endcase
   end

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state     <= ST_IDLE;
         beat_cnt  <= '0;
         ring_ptr  <= '0;
         line_done <= 1'b0;
      end
      else
      begin
         state     <= next_state;
         line_done <= xfer_end;
         if (state == ST_DATA)
            beat_cnt <= beat_cnt + 1'b1;
         // Next line slot, wraps inside the region
         if (xfer_end)
            ring_ptr <= BUS_ADDR_W'((ring_ptr + LINE_BYTES) % REGION_BYTES);
      end
   end

   assign br = (state != ST_IDLE);

   always_comb
   begin
      beat = '0;
      if (state == ST_HDR)
      begin
         beat.valid = 1'b1;
         beat.hdr   = 1'b1;
         beat.rw    = 1'b1;
         beat.addr  = BASE_ADDR + ring_ptr;
         beat.size  = BUS_SIZE_W'(LINE_BYTES);
      end
      else if (state == ST_DATA)
      begin
         beat.valid = 1'b1;
         beat.data  = xfer_buf[beat_cnt*BUS_DATA_W +: BUS_DATA_W];
      end
   end

   // Bus is driven only under a grant from the arbiter
   a_beat_granted: assert property (@(posedge bus_clk) disable iff (!arst_n)
      beat.valid |-> bg);

   // Slave ends the transfer on the fourth data beat
   a_ack_last_beat: assert property (@(posedge bus_clk) disable iff (!arst_n)
      xfer_end |-> &beat_cnt);

endmodule

// File: logic/mem_bus_slave.sv
/* Line memory slave: write decode, size countdown, ack and a registered read port */

`timescale 1ns/1ps

module mem_bus_slave
(
   input  logic                   bus_clk,
   input  logic                   arst_n,
   input  sys_bus_pkg::bus_beat_t beat,
   output logic                   ack,
   input  logic [6:0]             rd_addr,
   output logic [31:0]            rd_data
);

   import sys_bus_pkg::*;

   logic [BUS_DATA_W-1:0] mem [MEM_WORDS];
   // Marks words written since reset, unwritten words read as zero
   logic [MEM_WORDS-1:0]  written;

   logic [6:0]            idx_q;
   logic [BUS_SIZE_W-1:0] rem_q;
   logic                  hdr_beat, data_beat;

   assign hdr_beat  = beat.valid && beat.hdr;
   assign data_beat = beat.valid && !beat.hdr;

   // Last data beat brings the remaining size to zero
   assign ack = data_beat && (rem_q == BUS_SIZE_W'(BUS_DATA_W/8));

   // Transfer decode and size countdown
   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         idx_q <= '0;
         rem_q <= '0;
      end
      else if (hdr_beat)
      begin
         idx_q <= beat.addr[8:2];
         rem_q <= beat.size;
      end
      else if (data_beat)
      begin
         idx_q <= idx_q + 1'b1;
         rem_q <= rem_q - BUS_SIZE_W'(BUS_DATA_W/8);
      end
   end

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
         written <= '0;
      else if (data_beat)
         written[idx_q] <= 1'b1;
   end

   // Word is stored in the cycle its beat arrives
   always_ff @(posedge bus_clk)
   begin
      if (data_beat)
         mem[idx_q] <= beat.data;
   end

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
         rd_data <= '0;
      else if (written[rd_addr])
         rd_data <= mem[rd_addr];
      else
         rd_data <= '0;
   end

   // Masters send only full-line writes
   a_hdr_format: assert property (@(posedge bus_clk) disable iff (!arst_n)
      hdr_beat |-> (beat.rw && beat.size == BUS_SIZE_W'(LINE_BYTES)));

   // Data beats belong to an open transfer
   a_data_after_hdr: assert property (@(posedge bus_clk) disable iff (!arst_n)
      data_beat |-> (rem_q != '0));

   // A header is followed by its data beats back to back
   a_beats_back_to_back: assert property (@(posedge bus_clk) disable iff (!arst_n)
      hdr_beat |=> data_beat [*LINE_BEATS]);

endmodule

// File: logic/sys_bus_pkg.sv
/* System bus sizes, region base addresses, the bus beat struct and the key struct */

package sys_bus_pkg;

   // Bus field widths
   localparam int BUS_ADDR_W = 16;
   localparam int BUS_DATA_W = 32;
   localparam int BUS_SIZE_W = 12;

   // Every transfer moves one full line of key codes
   localparam int LINE_BYTES = 16;
   localparam int LINE_BEATS = 4;

   // Each keyboard owns a ring of 16 lines
   localparam int REGION_BYTES = 256;

   // Line memory, 32-bit words
   localparam int MEM_WORDS = 128;

   localparam logic [BUS_ADDR_W-1:0] KBD0_BASE = 16'h7000;
   localparam logic [BUS_ADDR_W-1:0] KBD1_BASE = 16'h7100;

   localparam int NUM_MASTERS = 2;

   // One bus cycle
   // header beat carries addr, size and rw; data beats carry data
   typedef struct packed
   {
      logic                  valid;
      logic                  hdr;
      logic                  rw;
      logic [BUS_ADDR_W-1:0] addr;
      logic [BUS_SIZE_W-1:0] size;
      logic [BUS_DATA_W-1:0] data;
   } bus_beat_t;

   // Key code with a one-cycle strobe
   typedef struct packed
   {
      logic       valid;
      logic [7:0] code;
   } key_t;

endpackage

// File: logic/sys_bus_top.sv
/* System bus top: two keyboard masters, arbiter, bus OR and memory slave */

`timescale 1ns/1ps

module sys_bus_top
(
   input  logic              bus_clk,
   input  logic              arst_n,
   input  sys_bus_pkg::key_t key0,
   input  sys_bus_pkg::key_t key1,
   input  logic [6:0]        rd_addr,
   output logic [31:0]       rd_data,
   output logic [1:0]        line_done,
   output logic [1:0]        overflow
);

   import sys_bus_pkg::*;

   logic [NUM_MASTERS-1:0] br;
   logic [NUM_MASTERS-1:0] bg;
   logic                   ack;
   bus_beat_t              beat0, beat1;
   bus_beat_t              bus_beat;

   kbd_bus_controller
   #(
      .BASE_ADDR (KBD0_BASE)
   ) kbd0_inst
   (
      .bus_clk   (bus_clk),
      .arst_n    (arst_n),
      .key       (key0),
      .bg        (bg[0]),
      .ack       (ack),
      .br        (br[0]),
      .beat      (beat0),
      .line_done (line_done[0]),
      .overflow  (overflow[0])
   );

   kbd_bus_controller
   #(
      .BASE_ADDR (KBD1_BASE)
   ) kbd1_inst
   (
      .bus_clk   (bus_clk),
      .arst_n    (arst_n),
      .key       (key1),
      .bg        (bg[1]),
      .ack       (ack),
      .br        (br[1]),
      .beat      (beat1),
      .line_done (line_done[1]),
      .overflow  (overflow[1])
   );

   bus_arbiter bus_arbiter_inst
   (
      .bus_clk (bus_clk),
      .arst_n  (arst_n),
      .br      (br),
      .ack     (ack),
      .bg      (bg)
   );

   // Grants are exclusive, so an idle master contributes all zeros
   assign bus_beat = bus_beat_t'(beat0 | beat1);

   mem_bus_slave mem_bus_slave_inst
   (
      .bus_clk (bus_clk),
      .arst_n  (arst_n),
      .beat    (bus_beat),
      .ack     (ack),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

// File: sim/sys_bus_checker.sv
/* Testbench checker: reference model of both key streams and the line memory,
   compares readback, line_done timing and counts, and overflow */

`timescale 1ns/1ps

module sys_bus_checker
(
   input  logic              bus_clk,
   input  logic              arst_n,
   input  sys_bus_pkg::key_t key0,
   input  sys_bus_pkg::key_t key1,
   input  logic [1:0]        line_done,
   input  logic [1:0]        overflow,
   input  logic              rd_en,
   input  logic [6:0]        rd_addr,
   input  logic [31:0]       rd_data,
   input  logic              test_end,
   output int                err_cnt,
   output int                chk_cnt
);

   import sys_bus_pkg::*;

   // Both masters fill a line in the same cycle, the second one waits for
   // the whole first transfer and the idle cycle of the arbiter
   localparam int MAX_LATENCY = 15;
   localparam int MAX_KEYS    = 1024;
   localparam int MAX_LINES   = MAX_KEYS / LINE_BYTES;

   logic [7:0]  stream    [NUM_MASTERS][MAX_KEYS];
   int          comp_cyc  [NUM_MASTERS][MAX_LINES];
   int          key_cnt   [NUM_MASTERS];
   int          done_cnt  [NUM_MASTERS];
   logic [31:0] model_mem [MEM_WORDS];
   int          cyc;
   logic        rd_pend;
   logic [6:0]  rd_idx;

   // Appends a key and notes the cycle in which its line filled up
   task automatic record_key(input int m, input logic [7:0] code);
      stream[m][key_cnt[m]] = code;
      if (key_cnt[m] % LINE_BYTES == LINE_BYTES - 1)
         comp_cyc[m][key_cnt[m] / LINE_BYTES] = cyc;
      key_cnt[m]++;
   endtask

   // Expected line goes to the next slot of the master's ring
   task automatic line_complete(input int m);
      int                    n;
      int                    lat;
      int                    idx;
      logic [BUS_ADDR_W-1:0] addr;
      logic [31:0]           word;
      chk_cnt++;
      n = done_cnt[m];
      if (n >= key_cnt[m] / LINE_BYTES)
      begin
         $display("Master %0d strobed line_done with no completed line at cycle %0d", m, cyc);
         err_cnt++;
      end
      else
      begin
         lat = cyc - comp_cyc[m][n];
         if (lat > MAX_LATENCY)
         begin
            $display("Master %0d line %0d: line_done came %0d cycles after the line filled",
                     m, n, lat);
            err_cnt++;
         end
         addr = (m == 0) ? KBD0_BASE : KBD1_BASE;
         addr = addr + BUS_ADDR_W'((n * LINE_BYTES) % REGION_BYTES);
         idx  = (int'(addr) / 4) % MEM_WORDS;
         // First key of the line is the low byte of the first word
         for (int j = 0; j < LINE_BEATS; j++)
         begin
            for (int b = 0; b < 4; b++)
               word[b*8 +: 8] = stream[m][n*LINE_BYTES + j*4 + b];
            model_mem[idx + j] = word;
         end
         done_cnt[m]++;
      end
   endtask

   always @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         cyc     = 0;
         err_cnt = 0;
         chk_cnt = 0;
         rd_pend = 1'b0;
         rd_idx  = '0;
         for (int m = 0; m < NUM_MASTERS; m++)
         begin
            key_cnt[m]  = 0;
            done_cnt[m] = 0;
         end
         for (int w = 0; w < MEM_WORDS; w++)
            model_mem[w] = '0;
      end
      else
      begin
         cyc++;
         // Read data belongs to the address of the previous cycle
         if (rd_pend)
         begin
            chk_cnt++;
            if (rd_data !== model_mem[rd_idx])
            begin
               $display("[FAIL] rd_data index %02h: expected %08h, got %08h",
                        rd_idx, model_mem[rd_idx], rd_data);
               err_cnt++;
            end
         end
         rd_pend = rd_en;
         rd_idx  = rd_addr;
         for (int m = 0; m < NUM_MASTERS; m++)
            if (line_done[m])
               line_complete(m);
         if (key0.valid)
            record_key(0, key0.code);
         if (key1.valid)
            record_key(1, key1.code);
         if (test_end)
         begin
            chk_cnt++;
            if (overflow !== 2'b00)
            begin
               $display("[FAIL] overflow: expected %h, got %h", 2'b00, overflow);
               err_cnt++;
            end
            for (int m = 0; m < NUM_MASTERS; m++)
            begin
               chk_cnt++;
               if (done_cnt[m] != key_cnt[m] / LINE_BYTES)
               begin
                  $display("[FAIL] line_done[%0d] count: expected %h, got %h",
                           m, key_cnt[m] / LINE_BYTES, done_cnt[m]);
                  err_cnt++;
               end
            end
         end
      end
   end

endmodule

// File: sim/sys_bus_tb.sv
/* Testbench top: clock, reset, random key stimulus, test sequence, readback,
   watchdog and summary */

`timescale 1ns/1ps

module sys_bus_tb;

   import sys_bus_pkg::*;

   // Keys over all tests, sizes the watchdog
   localparam int TOTAL_KEYS      = 80 + 2*96 + 320 + 2*128;
   localparam int WATCHDOG_CYCLES = TOTAL_KEYS*20 + 2000;

   logic        bus_clk;
   logic        arst_n;
   key_t        key0;
   key_t        key1;
   logic [6:0]  rd_addr;
   logic        rd_en;
   logic        test_end;
   logic [31:0] rd_data;
   logic [1:0]  line_done;
   logic [1:0]  overflow;
   int          err_cnt;
   int          chk_cnt;
   int          done0;
   int          done1;
   int          sent0;
   int          sent1;
   int          num_tests;
   int          seed;
   int unsigned junk;

   sys_bus_top sys_bus_top_inst
   (
      .bus_clk   (bus_clk),
      .arst_n    (arst_n),
      .key0      (key0),
      .key1      (key1),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .line_done (line_done),
      .overflow  (overflow)
   );

   sys_bus_checker sys_bus_checker_inst
   (
      .bus_clk   (bus_clk),
      .arst_n    (arst_n),
      .key0      (key0),
      .key1      (key1),
      .line_done (line_done),
      .overflow  (overflow),
      .rd_en     (rd_en),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .test_end  (test_end),
      .err_cnt   (err_cnt),
      .chk_cnt   (chk_cnt)
   );

   initial
   begin
      bus_clk = 1'b0;
      forever #10 bus_clk = ~bus_clk;
   end

   // Completed transfers per master, used to wait for the bus to drain
   always @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         done0 <= 0;
         done1 <= 0;
      end
      else
      begin
         if (line_done[0])
            done0 <= done0 + 1;
         if (line_done[1])
            done1 <= done1 + 1;
      end
   end

   // Random codes with up to max_gap idle cycles between keys of one input
   task automatic send_keys(input int n0, input int n1, input int max_gap);
      int rem0;
      int rem1;
      int gap0;
      int gap1;
      rem0 = n0;
      rem1 = n1;
      gap0 = 0;
      gap1 = 0;
      while (rem0 > 0 || rem1 > 0)
      begin
         @(negedge bus_clk);
         key0 = '0;
         key1 = '0;
         if (rem0 > 0 && gap0 == 0)
         begin
            key0.valid = 1'b1;
            key0.code  = 8'($urandom_range(255, 0));
            rem0--;
            gap0 = $urandom_range(max_gap, 0);
         end
         else if (gap0 > 0)
            gap0--;
         if (rem1 > 0 && gap1 == 0)
         begin
            key1.valid = 1'b1;
            key1.code  = 8'($urandom_range(255, 0));
            rem1--;
            gap1 = $urandom_range(max_gap, 0);
         end
         else if (gap1 > 0)
            gap1--;
      end
      @(negedge bus_clk);
      key0  = '0;
      key1  = '0;
      sent0 += n0;
      sent1 += n1;
   endtask

   // Waits for all lines, reads the whole memory, then lets the checker close the test
   task automatic finish_test(input string name);
      int err_before;
      err_before = err_cnt;
      while (done0 < sent0 / LINE_BYTES || done1 < sent1 / LINE_BYTES)
         @(negedge bus_clk);
      repeat (4) @(negedge bus_clk);
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         @(negedge bus_clk);
         rd_en   = 1'b1;
         rd_addr = 7'(i);
      end
      @(negedge bus_clk);
      rd_en = 1'b0;
      @(negedge bus_clk);
      test_end = 1'b1;
      @(negedge bus_clk);
      test_end = 1'b0;
      num_tests++;
      $display("Test %0d, %s: %0d errors", num_tests, name, err_cnt - err_before);
   endtask

   initial
   begin
      arst_n    = 1'b0;
      key0      = '0;
      key1      = '0;
      rd_addr   = '0;
      rd_en     = 1'b0;
      test_end  = 1'b0;
      sent0     = 0;
      sent1     = 0;
      num_tests = 0;
      seed      = 32'hfff2_0aed;
      junk      = $urandom(seed);
      repeat (8) @(posedge bus_clk);
      @(negedge bus_clk);
      arst_n = 1'b1;

      repeat (40) @(negedge bus_clk);
      finish_test("idle after reset");
      send_keys(80, 0, 3);
      finish_test("key0 alone with random gaps");
      send_keys(96, 96, 2);
      finish_test("both inputs at once");
      send_keys(0, 320, 1);
      finish_test("key1 ring wrap");
      send_keys(128, 128, 0);
      finish_test("keys every cycle on both inputs");

      $display("%0d tests, %0d checks, %0d errors", num_tests, chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge bus_clk);
      $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule
